/* Bender.yml */
package:
  name: soc_regs

sources:
  # Package first, then the RTL
  - src/soc_pkg.sv
  - src/wb_decoder.sv
  - src/bram_slave.sv
  - src/csr_bridge.sv
  - src/sysctl_csr.sv
  - src/soc_top.sv

  # Testbench
  - target: test
    files:
      - tests/soc_tb.sv

/* src/bram_slave.sv */
// --------------------------------------
// Block RAM on Wishbone
// Word organized, byte-select writes
// --------------------------------------

`default_nettype none

module bram_slave #(
	parameter int BRAM_ADR_W = 10
) (
	input  wire               sys_clk,
	input  wire               rst1,
	input  soc_pkg::wb_req_t  req_i,
	output soc_pkg::wb_rsp_t  rsp_o
);

	localparam int WORDS = 2 ** BRAM_ADR_W;

	soc_pkg::wb_data_t       mem [WORDS];
	soc_pkg::wb_data_t       rdat_q;
	logic [BRAM_ADR_W-1:0]   word_idx;
	logic                    ack_q;
	logic                    access;

	// Word index, upper address bits drop so it wraps in the region
	assign word_idx = req_i.adr[BRAM_ADR_W+1:2];
	assign access   = req_i.cyc & req_i.stb & ~ack_q;

	// Ack one cycle after stb
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// Memory array and read port
	always_ff @(posedge sys_clk) begin
		for (int lane = 0; lane < 4; lane++) begin
			if (access && req_i.we && req_i.sel[lane]) begin
				mem[word_idx][lane*8 +: 8] <= req_i.dat[lane*8 +: 8];
			end
		end
		rdat_q <= mem[word_idx];
	end

	assign rsp_o.dat = rdat_q;
	assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

/* src/csr_bridge.sv */
// --------------------------------------
// Wishbone to CSR bridge
// Address/write phase, then read capture
// Read data is the OR of all CSR banks
// --------------------------------------

`default_nettype none

module csr_bridge (
	input  wire                sys_clk,
	input  wire                rst1,
	input  soc_pkg::wb_req_t   req_i,
	output soc_pkg::wb_rsp_t   rsp_o,
	output soc_pkg::csr_req_t  csr_o,
	input  soc_pkg::wb_data_t  csr_rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_ACK
	} state_t;

	state_t             state;
	soc_pkg::csr_req_t  csr_q;
	soc_pkg::wb_data_t  rdat_q;
	logic               ack_q;

	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			state    <= ST_IDLE;
			ack_q    <= 1'b0;
			csr_q.we <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_i.cyc && req_i.stb) begin
						// Word address from byte address bits 15:2
						csr_q.a  <= req_i.adr[15:2];
						csr_q.we <= req_i.we;
						csr_q.dw <= req_i.dat;
						state    <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					// Write enable lasts one cycle only
					csr_q.we <= 1'b0;
					rdat_q   <= csr_rdata_i;
					ack_q    <= 1'b1;
					state    <= ST_ACK;
				end
				ST_ACK: begin
					// Master drops stb after this ack
					ack_q <= 1'b0;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign csr_o     = csr_q;
	assign rsp_o.dat = rdat_q;
	assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

/* src/soc_pkg.sv */
// --------------------------------------
// Shared SoC definitions
// Wishbone request and response structs
// CSR bus struct and address fields
// Region codes, CSR bank, register map
// Filler word of unmapped regions
// --------------------------------------

`default_nettype none

package soc_pkg;

	// --------------------------------------
	// Wishbone bus
	// --------------------------------------

	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_sel_t;

	// Master to slave
	typedef struct packed {
		wb_adr_t  adr;
		wb_data_t dat;
		wb_sel_t  sel;
		logic     we;
		logic     cyc;
		logic     stb;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		wb_data_t dat;
		logic     ack;
	} wb_rsp_t;

	// --------------------------------------
	// CSR bus
	// --------------------------------------

	// Bank in the top 4 bits, register index below
	typedef logic [13:0] csr_adr_t;

	// Bridge to bank
	typedef struct packed {
		csr_adr_t a;
		logic     we;
		wb_data_t dw;
	} csr_req_t;

	// Top three address bits select the region
	localparam logic [2:0] REGION_BRAM = 3'b001;
	localparam logic [2:0] REGION_CSR  = 3'b100;

	// Returned by the decoder for unmapped regions
	localparam wb_data_t FILLER_WORD = 32'hABADFACE;

	// System controller bank
	localparam logic [3:0] SYSCTL_BANK = 4'h1;

	// System controller register map
	localparam logic [9:0] REG_GPIO_IN       = 10'd0;
	localparam logic [9:0] REG_GPIO_OUT      = 10'd1;
	localparam logic [9:0] REG_TIMER_CTRL    = 10'd2;
	localparam logic [9:0] REG_TIMER_COMPARE = 10'd3;
	localparam logic [9:0] REG_TIMER_COUNTER = 10'd4;
	localparam logic [9:0] REG_SYSTEM_ID     = 10'd5;

endpackage

`default_nettype wire

/* src/soc_top.sv */
// --------------------------------------
// SoC top level
// Decoder, block RAM, CSR bridge
// System controller
// --------------------------------------

`default_nettype none

module soc_top #(
	parameter int          BRAM_ADR_W = 10,
	parameter int          GPIO_IN_W  = 13,
	parameter int          GPIO_OUT_W = 14,
	parameter logic [31:0] SYSTEM_ID  = 32'h58343031
) (
	input  wire                    sys_clk,
	input  wire                    rst1,
	input  soc_pkg::wb_req_t       bus_req_i,
	output soc_pkg::wb_rsp_t       bus_rsp_o,
	input  wire  [7:0]             dipsw_i,
	input  wire  [4:0]             btn_i,
	output logic [GPIO_OUT_W-1:0]  gpio_o,
	output logic                   timer_irq_o
);

	soc_pkg::wb_req_t   ram_req;
	soc_pkg::wb_rsp_t   ram_rsp;
	soc_pkg::wb_req_t   csr_req;
	soc_pkg::wb_rsp_t   csr_rsp;
	soc_pkg::csr_req_t  csr_bus;
	soc_pkg::wb_data_t  csr_rdata;
	logic [GPIO_IN_W-1:0] gpio_in;

	// Switches above buttons
	assign gpio_in = GPIO_IN_W'({dipsw_i, btn_i});

	wb_decoder u_wb_decoder (
		.sys_clk   (sys_clk),
		.rst1      (rst1),
		.bus_req_i (bus_req_i),
		.bus_rsp_o (bus_rsp_o),
		.ram_req_o (ram_req),
		.ram_rsp_i (ram_rsp),
		.csr_req_o (csr_req),
		.csr_rsp_i (csr_rsp)
	);

	bram_slave #(
		.BRAM_ADR_W (BRAM_ADR_W)
	) u_bram_slave (
		.sys_clk (sys_clk),
		.rst1    (rst1),
		.req_i   (ram_req),
		.rsp_o   (ram_rsp)
	);

	// Only the system controller drives the CSR read data
	csr_bridge u_csr_bridge (
		.sys_clk     (sys_clk),
		.rst1        (rst1),
		.req_i       (csr_req),
		.rsp_o       (csr_rsp),
		.csr_o       (csr_bus),
		.csr_rdata_i (csr_rdata)
	);

	sysctl_csr #(
		.GPIO_IN_W  (GPIO_IN_W),
		.GPIO_OUT_W (GPIO_OUT_W),
		.SYSTEM_ID  (SYSTEM_ID)
	) u_sysctl_csr (
		.sys_clk     (sys_clk),
		.rst1        (rst1),
		.csr_i       (csr_bus),
		.csr_rdata_o (csr_rdata),
		.gpio_i      (gpio_in),
		.gpio_o      (gpio_o),
		.timer_irq_o (timer_irq_o)
	);

endmodule

`default_nettype wire

/* src/sysctl_csr.sv */
// --------------------------------------
// System controller CSR bank
// GPIO inputs and outputs
// One-shot timer with interrupt
// Read-only system ID
// --------------------------------------

`default_nettype none

module sysctl_csr #(
	parameter int          GPIO_IN_W  = 13,
	parameter int          GPIO_OUT_W = 14,
	parameter logic [31:0] SYSTEM_ID  = 32'h58343031
) (
	input  wire                    sys_clk,
	input  wire                    rst1,
	input  soc_pkg::csr_req_t      csr_i,
	output soc_pkg::wb_data_t      csr_rdata_o,
	input  wire  [GPIO_IN_W-1:0]   gpio_i,
	output logic [GPIO_OUT_W-1:0]  gpio_o,
	output logic                   timer_irq_o
);

	logic                   bank_sel;
	logic [9:0]             reg_idx;
	logic [GPIO_IN_W-1:0]   gpio_in_q;
	logic                   timer_en;
	soc_pkg::wb_data_t      timer_compare;
	soc_pkg::wb_data_t      timer_counter;

	// Bank match on the top CSR address bits
	assign bank_sel = (csr_i.a[13:10] == soc_pkg::SYSCTL_BANK);
	assign reg_idx  = csr_i.a[9:0];

	// --------------------------------------
	// GPIO
	// --------------------------------------

	// Single register stage on the switch and button inputs
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			gpio_in_q <= '0;
		end else begin
			gpio_in_q <= gpio_i;
		end
	end

	// --------------------------------------
	// Timer and register writes
	// --------------------------------------

	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			gpio_o        <= '0;
			timer_en      <= 1'b0;
			timer_compare <= '0;
			timer_counter <= '0;
			timer_irq_o   <= 1'b0;
		end else begin
			timer_irq_o <= 1'b0;
			if (timer_en) begin
				// Match ends the count and fires the interrupt once
				if (timer_counter == timer_compare) begin
					timer_counter <= '0;
					timer_en      <= 1'b0;
					timer_irq_o   <= 1'b1;
				end else begin
					timer_counter <= timer_counter + 32'd1;
				end
			end
			// Bus writes take priority over the count
			if (bank_sel && csr_i.we) begin
				case (reg_idx)
					soc_pkg::REG_GPIO_OUT:      gpio_o <= csr_i.dw[GPIO_OUT_W-1:0];
					soc_pkg::REG_TIMER_CTRL:    timer_en <= csr_i.dw[0];
					soc_pkg::REG_TIMER_COMPARE: timer_compare <= csr_i.dw;
					soc_pkg::REG_TIMER_COUNTER: timer_counter <= csr_i.dw;
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------
	// Read data
	// --------------------------------------

	// Zero outside this bank, so the OR tree stays clean
	always_comb begin
		csr_rdata_o = '0;
		if (bank_sel) begin
			case (reg_idx)
				soc_pkg::REG_GPIO_IN:       csr_rdata_o = 32'(gpio_in_q);
				soc_pkg::REG_GPIO_OUT:      csr_rdata_o = 32'(gpio_o);
				soc_pkg::REG_TIMER_CTRL:    csr_rdata_o = {31'd0, timer_en};
				soc_pkg::REG_TIMER_COMPARE: csr_rdata_o = timer_compare;
				soc_pkg::REG_TIMER_COUNTER: csr_rdata_o = timer_counter;
				soc_pkg::REG_SYSTEM_ID:     csr_rdata_o = SYSTEM_ID;
				default:                    csr_rdata_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/wb_decoder.sv */
// --------------------------------------
// Wishbone region decoder
// Strobe routing to RAM and CSR bridge
// Response multiplexer
// Default responder with filler word
// --------------------------------------

`default_nettype none

module wb_decoder (
	input  wire               sys_clk,
	input  wire               rst1,
	input  soc_pkg::wb_req_t  bus_req_i,
	output soc_pkg::wb_rsp_t  bus_rsp_o,
	output soc_pkg::wb_req_t  ram_req_o,
	input  soc_pkg::wb_rsp_t  ram_rsp_i,
	output soc_pkg::wb_req_t  csr_req_o,
	input  soc_pkg::wb_rsp_t  csr_rsp_i
);

	logic [2:0] region;
	logic       hit_bram;
	logic       hit_csr;
	logic       hit_none;
	logic       def_ack;

	// Region from the top three address bits
	assign region   = bus_req_i.adr[31:29];
	assign hit_bram = (region == soc_pkg::REGION_BRAM);
	assign hit_csr  = (region == soc_pkg::REGION_CSR);
	assign hit_none = ~hit_bram & ~hit_csr;

	// --------------------------------------
	// Strobe routing
	// --------------------------------------

	// Same request to both slaves, only one sees stb
	always_comb begin
		ram_req_o     = bus_req_i;
		ram_req_o.stb = bus_req_i.stb & hit_bram;
		csr_req_o     = bus_req_i;
		csr_req_o.stb = bus_req_i.stb & hit_csr;
	end

	// --------------------------------------
	// Default responder
	// --------------------------------------

	// One ack per access, cleared while the master still holds stb
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			def_ack <= 1'b0;
		end else begin
			def_ack <= bus_req_i.cyc & bus_req_i.stb & hit_none & ~def_ack;
		end
	end

	// --------------------------------------
	// Response multiplexer
	// --------------------------------------

	always_comb begin
		if (hit_bram) begin
			bus_rsp_o = ram_rsp_i;
		end else if (hit_csr) begin
			bus_rsp_o = csr_rsp_i;
		end else begin
			bus_rsp_o.dat = soc_pkg::FILLER_WORD;
			bus_rsp_o.ack = def_ack;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
src/soc_pkg.sv
src/wb_decoder.sv
src/bram_slave.sv
src/csr_bridge.sv
src/sysctl_csr.sv
src/soc_top.sv
tests/soc_tb.sv

/* tests/soc_tb.sv */
// --------------------------------------
// Testbench for the SoC register side
// Clock, reset, bus master tasks
// Reference model of RAM, GPIO and timer
// Random stimulus and compare tasks
// --------------------------------------

`default_nettype none

module soc_tb;

	localparam int DRV_DLY     = 2;
	localparam int ACK_TIMEOUT = 50;
	localparam int POLL_LIMIT  = 100;
	localparam int RAM_WORDS   = 1024;
	localparam int GPIO_OUT_W  = 14;
	localparam logic [31:0] SYSTEM_ID   = 32'h58343031;
	localparam logic [31:0] FILLER_WORD = 32'hABADFACE;

	logic                   sys_clk;
	logic                   rst1;
	soc_pkg::wb_req_t       bus_req;
	soc_pkg::wb_rsp_t       bus_rsp;
	logic [7:0]             dipsw;
	logic [4:0]             btn;
	logic [GPIO_OUT_W-1:0]  gpio;
	logic                   timer_irq;

	// Reference model
	soc_pkg::wb_data_t      ram_model [RAM_WORDS];
	bit                     ram_valid [RAM_WORDS];
	logic [GPIO_OUT_W-1:0]  gpio_model;
	int                     irq_pulses;
	integer                 seed;

	soc_top u_soc_top (
		.sys_clk     (sys_clk),
		.rst1        (rst1),
		.bus_req_i   (bus_req),
		.bus_rsp_o   (bus_rsp),
		.dipsw_i     (dipsw),
		.btn_i       (btn),
		.gpio_o      (gpio),
		.timer_irq_o (timer_irq)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// One count per pulse, irq lasts a single cycle
	always @(negedge sys_clk) begin
		if (timer_irq === 1'b1) begin
			irq_pulses++;
		end
	end

	// --------------------------------------
	// Failure reporting and compares
	// --------------------------------------

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input soc_pkg::wb_data_t exp,
		input soc_pkg::wb_data_t act);
		if (act !== exp) begin
			fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_gpio(input string name, input logic [GPIO_OUT_W-1:0] exp,
		input logic [GPIO_OUT_W-1:0] act);
		if (act !== exp) begin
			fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	// --------------------------------------
	// Bus master
	// --------------------------------------

	// Classic cycle, held until ack is seen, then one idle cycle
	task automatic bus_access(input soc_pkg::wb_adr_t adr, input soc_pkg::wb_data_t dat,
		input soc_pkg::wb_sel_t sel, input logic we, output soc_pkg::wb_data_t rdat);
		int waited;
		@(posedge sys_clk);
		#DRV_DLY;
		bus_req.adr = adr;
		bus_req.dat = dat;
		bus_req.sel = sel;
		bus_req.we  = we;
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		waited = 0;
		@(negedge sys_clk);
		while (bus_rsp.ack !== 1'b1) begin
			waited++;
			if (waited > ACK_TIMEOUT) begin
				fail_run($sformatf("Timeout: no bus ack for address %h", adr));
			end
			@(negedge sys_clk);
		end
		rdat = bus_rsp.dat;
		@(posedge sys_clk);
		#DRV_DLY;
		bus_req.cyc = 1'b0;
		bus_req.stb = 1'b0;
		bus_req.we  = 1'b0;
		// Ack lasts a single cycle per access
		@(negedge sys_clk);
		if (bus_rsp.ack !== 1'b0) begin
			fail_run($sformatf("Bus ack stayed high after the access to %h", adr));
		end
	endtask

	task automatic bus_write(input soc_pkg::wb_adr_t adr, input soc_pkg::wb_data_t dat,
		input soc_pkg::wb_sel_t sel);
		soc_pkg::wb_data_t ignored;
		bus_access(adr, dat, sel, 1'b1, ignored);
	endtask

	task automatic bus_read(input soc_pkg::wb_adr_t adr, output soc_pkg::wb_data_t dat);
		bus_access(adr, '0, 4'hF, 1'b0, dat);
	endtask

	// --------------------------------------
	// Model helpers
	// --------------------------------------

	// Bank in byte address bits 15:12, register in 11:2
	function automatic soc_pkg::wb_adr_t csr_addr(input logic [3:0] bank,
		input logic [9:0] idx);
		return {soc_pkg::REGION_CSR, 13'd0, bank, idx, 2'b00};
	endfunction

	function automatic soc_pkg::wb_adr_t rand_ram_addr();
		logic [31:0] r;
		r = $random(seed);
		return {soc_pkg::REGION_BRAM, r[28:0]};
	endfunction

	function automatic soc_pkg::wb_data_t merge_lanes(input soc_pkg::wb_data_t old_w,
		input soc_pkg::wb_data_t new_w, input soc_pkg::wb_sel_t sel);
		soc_pkg::wb_data_t res;
		int lane;
		res = old_w;
		for (lane = 0; lane < 4; lane++) begin
			if (sel[lane]) begin
				res[lane*8 +: 8] = new_w[lane*8 +: 8];
			end
		end
		return res;
	endfunction

	// Word index is address bits 11:2, so the region wraps every 4 KiB
	task automatic ram_write(input soc_pkg::wb_adr_t adr, input soc_pkg::wb_data_t dat,
		input soc_pkg::wb_sel_t sel);
		int idx;
		idx = adr[11:2];
		bus_write(adr, dat, sel);
		ram_model[idx] = merge_lanes(ram_model[idx], dat, sel);
		if (sel == 4'hF) begin
			ram_valid[idx] = 1'b1;
		end
	endtask

	// --------------------------------------
	// Tests
	// --------------------------------------

	task automatic test_bram();
		soc_pkg::wb_adr_t  adrs [$];
		soc_pkg::wb_adr_t  alias_adr;
		soc_pkg::wb_data_t rd;
		logic [31:0]       r;
		for (int n = 0; n < 40; n++) begin
			adrs.push_back(rand_ram_addr());
			ram_write(adrs[n], $random(seed), 4'hF);
		end
		foreach (adrs[n]) begin
			bus_read(adrs[n], rd);
			check_word("bram read", ram_model[adrs[n][11:2]], rd);
			// Same word through different upper address bits
			r = $random(seed);
			alias_adr = {soc_pkg::REGION_BRAM, r[28:12], adrs[n][11:0]};
			bus_read(alias_adr, rd);
			check_word("bram wrap", ram_model[adrs[n][11:2]], rd);
		end
	endtask

	task automatic test_lanes();
		soc_pkg::wb_adr_t  adr;
		soc_pkg::wb_data_t rd;
		logic [31:0]       r;
		for (int n = 0; n < 40; n++) begin
			adr = rand_ram_addr();
			if (!ram_valid[adr[11:2]]) begin
				ram_write(adr, $random(seed), 4'hF);
			end
			r = $random(seed);
			ram_write(adr, $random(seed), r[3:0]);
			bus_read(adr, rd);
			check_word("byte lanes", ram_model[adr[11:2]], rd);
		end
	endtask

	task automatic test_gpio();
		soc_pkg::wb_data_t rd;
		logic [31:0]       r;
		for (int n = 0; n < 20; n++) begin
			r = $random(seed);
			bus_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_OUT), r, 4'hF);
			gpio_model = r[GPIO_OUT_W-1:0];
			check_gpio("gpio pins", gpio_model, gpio);
			bus_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_OUT), rd);
			check_word("gpio readback", 32'(gpio_model), rd);
		end
		for (int n = 0; n < 20; n++) begin
			r = $random(seed);
			@(posedge sys_clk);
			#DRV_DLY;
			dipsw = r[12:5];
			btn   = r[4:0];
			// Input register stage needs a cycle or two
			repeat (3) @(posedge sys_clk);
			bus_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_IN), rd);
			check_word("gpio inputs", {19'd0, r[12:5], r[4:0]}, rd);
		end
	endtask

	task automatic test_const();
		soc_pkg::wb_data_t rd;
		soc_pkg::wb_adr_t  low_adr;
		logic [31:0]       r;
		logic [2:0]        region;
		bus_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_SYSTEM_ID), rd);
		check_word("system id", SYSTEM_ID, rd);
		bus_read(csr_addr(soc_pkg::SYSCTL_BANK, 10'd7), rd);
		check_word("unknown index", 32'd0, rd);
		bus_read(csr_addr(4'h2, soc_pkg::REG_GPIO_OUT), rd);
		check_word("other bank", 32'd0, rd);
		for (int k = 0; k < 8; k++) begin
			region = k[2:0];
			if (region != soc_pkg::REGION_BRAM && region != soc_pkg::REGION_CSR) begin
				r = $random(seed);
				low_adr = {soc_pkg::REGION_BRAM, r[28:0]};
				ram_write(low_adr, $random(seed), 4'hF);
				bus_write({region, r[28:0]}, $random(seed), 4'hF);
				bus_read({region, r[28:0]}, rd);
				check_word("filler read", FILLER_WORD, rd);
				bus_read(low_adr, rd);
				check_word("filler write vs ram", ram_model[low_adr[11:2]], rd);
				// Register offset of gpio out, but outside the CSR region
				bus_write({region, 13'd0, soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_OUT, 2'b00},
					$random(seed), 4'hF);
				check_gpio("filler write vs gpio", gpio_model, gpio);
			end
		end
	endtask

	task automatic test_timer();
		soc_pkg::wb_data_t rd;
		logic [31:0]       r;
		int                polls;
		for (int n = 0; n < 4; n++) begin
			r = $random(seed);
			bus_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COUNTER), 0, 4'hF);
			bus_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COMPARE),
				{28'd0, r[3:0]} + 32'd2, 4'hF);
			irq_pulses = 0;
			bus_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_CTRL), 1, 4'hF);
			// Enable self-clears on the compare match
			polls = 0;
			rd = 32'd1;
			while (rd[0] !== 1'b0) begin
				polls++;
				if (polls > POLL_LIMIT) begin
					fail_run("Timeout: timer enable never cleared");
				end
				bus_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_CTRL), rd);
			end
			check_word("timer irq pulses", 32'd1, 32'(irq_pulses));
			bus_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COUNTER), rd);
			check_word("timer counter", 32'd0, rd);
		end
	endtask

	// --------------------------------------
	// Main sequence
	// --------------------------------------

	initial begin
		seed       = 32'h4522;
		rst1       = 1'b0;
		bus_req    = '0;
		dipsw      = '0;
		btn        = '0;
		gpio_model = '0;
		irq_pulses = 0;
		repeat (5) @(posedge sys_clk);
		#DRV_DLY;
		rst1 = 1'b1;
		check_gpio("gpio after reset", '0, gpio);
		check_word("irq after reset", 32'd0, {31'd0, timer_irq});
		test_bram();
		test_lanes();
		test_gpio();
		test_const();
		test_timer();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
